//--- logic/sysctl_pkg.sv
// Bus widths, address map, simulation sizes and the bus request and response structs
`default_nettype none

package sysctl_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// Block RAM at the bottom of the map
	localparam int BRAM_WORDS = 256;
	localparam int BRAM_AW = $clog2(BRAM_WORDS);
	localparam logic [ADDR_W-1:0] BRAM_BYTES = ADDR_W'(BRAM_WORDS * 4);

	// Regions selected by the top nibble
	localparam logic [ADDR_W-1:0] REGION_MASK = 32'hf000_0000;
	localparam logic [ADDR_W-1:0] REGION_SYS = 32'hf000_0000;

	// System register offsets, low half of the address
	localparam int OFFS_W = 16;
	localparam logic [OFFS_W-1:0] REG_LED = 16'h1000;
	localparam logic [OFFS_W-1:0] REG_RTC = 16'h1100;

	// LED pin is active low
	localparam logic LED_OFF = 1'b1;

	// Clock cycles per second
	localparam int RTC_TICKS = 50;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		// All zero for a read
		logic [STRB_W-1:0] wstrb;
	} mem_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic ready;
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- logic/rtc_counter.sv
// Real-time clock with cycle prescaler and running seconds counter
`timescale 1ns/1ps
`default_nettype none

module rtc_counter import sysctl_pkg::*; #(
	parameter int TICKS = RTC_TICKS
) (
	input logic clk,
	input logic resetn,
	output logic [DATA_W-1:0] secs_o
);

	typedef logic [$clog2(TICKS)-1:0] presc_t;

	presc_t presc_q;
	logic [DATA_W-1:0] secs_q;
	logic wrap;

	// Last cycle of the current second
	assign wrap = presc_q == presc_t'(TICKS - 1);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			presc_q <= '0;
			secs_q <= '0;
		end else if (wrap) begin
			presc_q <= '0;
			secs_q <= secs_q + DATA_W'(1);
		end else begin
			presc_q <= presc_q + presc_t'(1);
		end
	end

	assign secs_o = secs_q;

endmodule

`default_nettype wire

//--- logic/bram_store.sv
// Block RAM target with byte-lane write strobes and a registered read port
`timescale 1ns/1ps
`default_nettype none

module bram_store import sysctl_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic sel_i,
	input mem_req_t req_i,
	output mem_rsp_t rsp_o
);

	logic [DATA_W-1:0] mem [0:BRAM_WORDS-1];

	logic [BRAM_AW-1:0] word_idx;
	logic [DATA_W-1:0] rdata_q;
	logic ack_q;

	// Word index, byte offset dropped
	assign word_idx = req_i.addr[BRAM_AW+1:2];

	// Strobed lanes are written, the old word is read out
	always_ff @(posedge clk) begin
		if (sel_i) begin
			for (int lane = 0; lane < STRB_W; lane++) begin
				if (req_i.wstrb[lane]) begin
					mem[word_idx][lane*8 +: 8] <= req_i.wdata[lane*8 +: 8];
				end
			end
			rdata_q <= mem[word_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= sel_i;
		end
	end

	// Zero data outside the acknowledge cycle
	assign rsp_o.rdata = ack_q ? rdata_q : '0;
	assign rsp_o.ready = ack_q;

endmodule

`default_nettype wire

//--- logic/sysreg_block.sv
// System register target holding the LED register and the seconds readout
`timescale 1ns/1ps
`default_nettype none

module sysreg_block import sysctl_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic sel_i,
	input mem_req_t req_i,
	input logic [DATA_W-1:0] secs_i,
	output mem_rsp_t rsp_o,
	output logic led_o
);

	logic [OFFS_W-1:0] offset;
	logic is_write;

	logic [DATA_W-1:0] rd_next;
	logic [DATA_W-1:0] rdata_q;
	logic ack_q;
	logic led_q;

	assign offset = req_i.addr[OFFS_W-1:0];
	assign is_write = |req_i.wstrb;

	// Read mux, unused offsets and writes return zero
	always_comb begin
		rd_next = '0;
		if (!is_write) begin
			case (offset)
				REG_LED: begin
					rd_next[0] = ~led_q;
				end
				REG_RTC: begin
					rd_next = secs_i;
				end
				default: begin
					rd_next = '0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			ack_q <= 1'b0;
			led_q <= LED_OFF;
		end else begin
			ack_q <= sel_i;
			// Pin is driven low to light the LED
			if (sel_i && is_write && offset == REG_LED) begin
				led_q <= ~req_i.wdata[0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sel_i) begin
			rdata_q <= rd_next;
		end
	end

	assign rsp_o.rdata = ack_q ? rdata_q : '0;
	assign rsp_o.ready = ack_q;

	assign led_o = led_q;

endmodule

`default_nettype wire

//--- logic/sysctl_top.sv
// System controller top with bus accept, region decode, unmapped acknowledge and response merge
`timescale 1ns/1ps
`default_nettype none

module sysctl_top import sysctl_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic mem_valid_i,
	input mem_req_t mem_req_i,
	output mem_rsp_t mem_rsp_o,
	output logic led_o
);

	logic bus_ready;
	logic accept;

	logic hit_bram;
	logic hit_sys;

	logic sel_bram;
	logic sel_sys;
	logic sel_none;

	mem_rsp_t bram_rsp;
	mem_rsp_t sys_rsp;
	mem_rsp_t none_rsp;
	logic none_ack_q;

	logic [DATA_W-1:0] secs;

	// Acknowledge currently on the bus, from any target
	assign bus_ready = bram_rsp.ready | sys_rsp.ready | none_rsp.ready;

	// A request is taken once, while no acknowledge is pending
	assign accept = mem_valid_i && !bus_ready;

	assign hit_bram = mem_req_i.addr < BRAM_BYTES;
	assign hit_sys = (mem_req_i.addr & REGION_MASK) == REGION_SYS;

	// Exactly one select per accepted request
	assign sel_bram = accept && hit_bram;
	assign sel_sys = accept && !hit_bram && hit_sys;
	assign sel_none = accept && !hit_bram && !hit_sys;

	// Unmapped requests still complete, with zero read data
	always_ff @(posedge clk) begin
		if (!resetn) begin
			none_ack_q <= 1'b0;
		end else begin
			none_ack_q <= sel_none;
		end
	end

	assign none_rsp.rdata = '0;
	assign none_rsp.ready = none_ack_q;

	bram_store bram_store_inst (
		.clk(clk),
		.resetn(resetn),
		.sel_i(sel_bram),
		.req_i(mem_req_i),
		.rsp_o(bram_rsp)
	);

	sysreg_block sysreg_block_inst (
		.clk(clk),
		.resetn(resetn),
		.sel_i(sel_sys),
		.req_i(mem_req_i),
		.secs_i(secs),
		.rsp_o(sys_rsp),
		.led_o(led_o)
	);

	rtc_counter #(
		.TICKS(RTC_TICKS)
	) rtc_counter_inst (
		.clk(clk),
		.resetn(resetn),
		.secs_o(secs)
	);

	// Idle targets drive zero data, so OR merges them
	assign mem_rsp_o.rdata = bram_rsp.rdata | sys_rsp.rdata | none_rsp.rdata;
	assign mem_rsp_o.ready = bus_ready;

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// Testbench clock with a 20 ns period and a reset held low for the first 3 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic resetn_o
);

	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// Released on a falling edge, clear of the sampling edge
	initial begin
		resetn_o = 1'b0;
		repeat (3) @(posedge clk_o);
		@(negedge clk_o);
		resetn_o = 1'b1;
	end

endmodule

`default_nettype wire

//--- verification/sysctl_checker.sv
// Bus protocol and LED pin assertions, bound into the system controller top
`timescale 1ns/1ps
`default_nettype none

module sysctl_checker import sysctl_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic valid_i,
	input logic accept_i,
	input mem_rsp_t rsp_i,
	input logic led_i
);

	// Acknowledge is a single-cycle pulse
	ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
		rsp_i.ready |=> !rsp_i.ready)
		else $error("ready stayed high for two cycles");

	ready_after_reset: assert property (@(posedge clk) !resetn |=> !rsp_i.ready)
		else $error("ready high in the cycle after reset");

	ready_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
		rsp_i.ready |-> $past(valid_i))
		else $error("ready without valid in the previous cycle");

	// LED pin moves only as a result of an accepted request
	led_on_accept: assert property (@(posedge clk) disable iff (!resetn)
		(led_i != $past(led_i)) |-> $past(accept_i))
		else $error("led_o changed without an accepted request");

endmodule

bind sysctl_top sysctl_checker sysctl_checker_inst (
	.clk(clk),
	.resetn(resetn),
	.valid_i(mem_valid_i),
	.accept_i(accept),
	.rsp_i(mem_rsp_o),
	.led_i(led_o)
);

`default_nettype wire

//--- verification/tb_sysctl.sv
// System controller testbench with bus stimulus, shadow model, response compare and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_sysctl import sysctl_pkg::*; ();

	localparam int RAND_OPS = 40;
	localparam int RTC_WAIT = 137;
	// Three cycles per access, the seconds wait and some margin
	localparam int TIMEOUT_CYCLES = (BRAM_WORDS + 4 * RAND_OPS + 40) * 3 + RTC_WAIT + 400;

	localparam int MODE_SKIP = 0;
	localparam int MODE_EXACT = 1;
	localparam int MODE_NEAR = 2;

	logic clk;
	logic resetn;
	logic mem_valid;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;
	logic led;

	logic [DATA_W-1:0] shadow [0:BRAM_WORDS-1];
	logic led_bit;
	logic [31:0] rng_state = 32'h8e4e;
	int cycle_count = 0;
	int run_cycles = 0;

	// Expected responses, oldest first
	string exp_name_q[$];
	logic [DATA_W-1:0] exp_val_q[$];
	int exp_mode_q[$];

	tb_clock_gen clock_gen_inst (
		.clk_o(clk),
		.resetn_o(resetn)
	);

	sysctl_top sysctl_top_inst (
		.clk(clk),
		.resetn(resetn),
		.mem_valid_i(mem_valid),
		.mem_req_i(mem_req),
		.mem_rsp_o(mem_rsp),
		.led_o(led)
	);

	task automatic end_in_failure();
		$display("Some tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_error(input string why);
		$display("ERROR: %s", why);
		end_in_failure();
	endtask

	task automatic check_rdata(input string name, input logic [DATA_W-1:0] exp_val,
			input logic [DATA_W-1:0] act_val);
		if (act_val !== exp_val) begin
			$display("MISMATCH %s expected %h actual %h", name, exp_val, act_val);
			end_in_failure();
		end
	endtask

	task automatic check_led(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("MISMATCH %s expected %b actual %b", name, exp_val, act_val);
			end_in_failure();
		end
	endtask

	function automatic logic [31:0] rand32();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic mem_req_t make_req(input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] wstrb);
		mem_req_t req;
		req.addr = addr;
		req.wdata = wdata;
		req.wstrb = wstrb;
		return req;
	endfunction

	function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
	endfunction

	// Expected read data from the shadow state before the access
	function automatic logic [DATA_W-1:0] expected_rdata(input mem_req_t req);
		logic [DATA_W-1:0] value;
		value = '0;
		if (req.addr < 32'(BRAM_WORDS * 4)) begin
			value = shadow[req.addr[BRAM_AW+1:2]];
		end else if ((req.addr & REGION_MASK) == REGION_SYS && req.wstrb == '0) begin
			if (req.addr[15:0] == REG_LED) begin
				value = DATA_W'(led_bit);
			end else if (req.addr[15:0] == REG_RTC) begin
				value = 32'(run_cycles / RTC_TICKS);
			end
		end
		return value;
	endfunction

	task automatic apply_write(input mem_req_t req);
		logic [BRAM_AW-1:0] idx;
		idx = req.addr[BRAM_AW+1:2];
		if (req.addr < 32'(BRAM_WORDS * 4)) begin
			for (int lane = 0; lane < STRB_W; lane++) begin
				if (req.wstrb[lane]) begin
					shadow[idx][lane*8 +: 8] = req.wdata[lane*8 +: 8];
				end
			end
		end else if ((req.addr & REGION_MASK) == REGION_SYS && req.wstrb != '0 &&
				req.addr[15:0] == REG_LED) begin
			led_bit = req.wdata[0];
		end
	endtask

	// Ready expected exactly one cycle after acceptance, for one cycle only
	task automatic bus_access(input string name, input mem_req_t req, input int mode);
		@(negedge clk);
		exp_name_q.push_back(name);
		exp_val_q.push_back(expected_rdata(req));
		exp_mode_q.push_back(mode);
		apply_write(req);
		mem_valid = 1'b1;
		mem_req = req;
		@(negedge clk);
		if (!mem_rsp.ready) begin
			report_error({name, ": no acknowledge one cycle after acceptance"});
		end
		@(negedge clk);
		if (mem_rsp.ready) begin
			report_error({name, ": acknowledge held for more than one cycle"});
		end
		mem_valid = 1'b0;
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (resetn) begin
			run_cycles++;
		end
		if (cycle_count >= TIMEOUT_CYCLES) begin
			report_error("timeout, the tests did not finish in time");
		end
	end

	always @(negedge clk) begin : compare_responses
		string name;
		logic [DATA_W-1:0] exp_val;
		int mode;
		if (resetn && mem_rsp.ready) begin
			if (exp_mode_q.size() == 0) begin
				report_error("acknowledge without an outstanding request");
			end else begin
				name = exp_name_q.pop_front();
				exp_val = exp_val_q.pop_front();
				mode = exp_mode_q.pop_front();
				// Seconds may tick once between estimate and sampling
				if (mode == MODE_EXACT) begin
					check_rdata(name, exp_val, mem_rsp.rdata);
				end else if (mode == MODE_NEAR && mem_rsp.rdata != exp_val + DATA_W'(1)) begin
					check_rdata(name, exp_val, mem_rsp.rdata);
				end
			end
		end
	end

	initial begin
		logic [BRAM_AW-1:0] idx [0:RAND_OPS-1];
		logic [31:0] r;
		logic [3:0] top;
		logic [ADDR_W-1:0] led_addr;
		logic [ADDR_W-1:0] rtc_addr;
		mem_valid = 1'b0;
		mem_req = '0;
		led_bit = 1'b0;
		led_addr = REGION_SYS | ADDR_W'(REG_LED);
		rtc_addr = REGION_SYS | ADDR_W'(REG_RTC);
		@(posedge resetn);
		check_led("led after reset", 1'b1, led);
		bus_access("secs after reset", make_req(rtc_addr, '0, '0), MODE_EXACT);

		// Old contents unknown during the fill
		for (int i = 0; i < BRAM_WORDS; i++) begin
			bus_access("bram fill", make_req(ADDR_W'(i) << 2, fill_word(ADDR_W'(i) << 2), '1),
				MODE_SKIP);
		end

		for (int i = 0; i < RAND_OPS; i++) begin
			idx[i] = BRAM_AW'(rand32());
			bus_access("bram word write", make_req(ADDR_W'({idx[i], 2'b00}), rand32(), '1),
				MODE_EXACT);
		end
		for (int i = 0; i < RAND_OPS; i++) begin
			bus_access("bram word read", make_req(ADDR_W'({idx[i], 2'b00}), '0, '0), MODE_EXACT);
		end

		for (int i = 0; i < RAND_OPS; i++) begin
			idx[i] = BRAM_AW'(rand32());
			r = rand32();
			bus_access("bram byte write", make_req(ADDR_W'({idx[i], 2'b00}), rand32(),
				(r[3:0] == 4'h0) ? 4'h1 : r[3:0]), MODE_EXACT);
		end
		for (int i = 0; i < RAND_OPS; i++) begin
			bus_access("bram byte read", make_req(ADDR_W'({idx[i], 2'b00}), '0, '0), MODE_EXACT);
		end

		// LED pin is the inverse of the written bit
		bus_access("led write on", make_req(led_addr, 32'h1, 4'h1), MODE_EXACT);
		check_led("led pin on", ~led_bit, led);
		bus_access("led read on", make_req(led_addr, '0, '0), MODE_EXACT);
		bus_access("led write off", make_req(led_addr, rand32() & 32'hffff_fffe, 4'hf),
			MODE_EXACT);
		check_led("led pin off", ~led_bit, led);
		bus_access("led read off", make_req(led_addr, '0, '0), MODE_EXACT);

		bus_access("above bram", make_req(32'h0000_0400, '0, '0), MODE_EXACT);
		for (int i = 0; i < 6; i++) begin
			r = rand32();
			top = (r[31:28] == 4'h0 || r[31:28] == 4'hf) ? 4'h7 : r[31:28];
			bus_access("unmapped read", make_req({top, r[27:0]}, '0, '0), MODE_EXACT);
			bus_access("unmapped write", make_req({top, r[27:0]}, rand32(), 4'hf), MODE_EXACT);
		end
		bus_access("sys offset 0", make_req(32'hf000_0000, '0, '0), MODE_EXACT);
		bus_access("sys offset 1004", make_req(32'hf000_1004, '0, '0), MODE_EXACT);
		bus_access("sys offset 2000", make_req(32'hf000_2000, '0, '0), MODE_EXACT);
		bus_access("sys unused write", make_req(32'hf000_1004, 32'h1, 4'hf), MODE_EXACT);
		check_led("led after unused writes", ~led_bit, led);

		repeat (RTC_WAIT) @(negedge clk);
		bus_access("secs after wait", make_req(rtc_addr, '0, '0), MODE_NEAR);

		@(negedge clk);
		if (exp_mode_q.size() == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			report_error("requests left without a response");
		end
	end

endmodule

`default_nettype wire

//--- compile.f
logic/sysctl_pkg.sv
logic/rtc_counter.sv
logic/bram_store.sv
logic/sysreg_block.sv
logic/sysctl_top.sv
verification/tb_clock_gen.sv
verification/sysctl_checker.sv
verification/tb_sysctl.sv

//--- Makefile
SIM := obj_dir/Vtb_sysctl
SRCS := $(shell grep -v '^+' compile.f)

.PHONY: all run clean

all: run

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_sysctl -f compile.f

# Failure shows in the log, an aborted run lacks the pass line
run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Some tests failed" sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
